// ==== hw/gpr_file.sv ====
// General register file, eight 32-bit registers
// Sized writeback and the ESI/EDI step for string moves
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  regacc_pkg::reg_num_t  rd0_num,
    output regacc_pkg::gpr_t      rd0_data,
    input  regacc_pkg::reg_num_t  rd1_num,
    output regacc_pkg::gpr_t      rd1_data,
    input  regacc_pkg::gpr_wb_t   wb,
    input  logic                  movs_step,
    input  regacc_pkg::op_size_e  step_size,
    input  logic                  flag_df
);

    regacc_pkg::gpr_t [7:0] regs;

    // Keep the untouched upper bits for byte and word writes
    function automatic regacc_pkg::gpr_t size_merge(input regacc_pkg::gpr_t old,
                                                    input regacc_pkg::gpr_t data,
                                                    input regacc_pkg::op_size_e size);
        case (size)
            regacc_pkg::size_byte: return {old[31:8], data[7:0]};
            regacc_pkg::size_word: return {old[31:16], data[15:0]};
            default:               return data;
        endcase
    endfunction

    // Step by the element size, down when DF is set
    function automatic regacc_pkg::gpr_t string_step(input regacc_pkg::gpr_t value,
                                                     input regacc_pkg::op_size_e size,
                                                     input logic df);
        regacc_pkg::gpr_t amount;
        case (size)
            regacc_pkg::size_byte: amount = 32'd1;
            regacc_pkg::size_word: amount = 32'd2;
            default:               amount = 32'd4;
        endcase
        return df ? value - amount : value + amount;
    endfunction

    assign rd0_data = regs[rd0_num];
    assign rd1_data = regs[rd1_num];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            if (movs_step) begin
                regs[regacc_pkg::reg_esi] <= string_step(regs[regacc_pkg::reg_esi],
                                                         step_size, flag_df);
                regs[regacc_pkg::reg_edi] <= string_step(regs[regacc_pkg::reg_edi],
                                                         step_size, flag_df);
            end
            // Writeback is last so it overrides the string step
            if (wb.en) begin
                regs[wb.num] <= size_merge(regs[wb.num], wb.data, wb.size);
            end
        end
    end

    // Decode must never hand a string move an unencoded size
    a_step_size_known: assert property (@(posedge clk) disable iff (!rst_n)
        movs_step |-> step_size inside {regacc_pkg::size_byte, regacc_pkg::size_word,
                                        regacc_pkg::size_dword});

endmodule

`default_nettype wire

// ==== hw/regacc_pkg.sv ====
// Shared widths, register numbers, enums and packed structs
// for the register access stage
`default_nettype none

package regacc_pkg;

    // Register widths and counts
    localparam int gpr_w     = 32;
    localparam int seg_w     = 16;
    localparam int reg_num_w = 3;
    localparam int num_seg   = 6;

    typedef logic [gpr_w-1:0]     gpr_t;
    typedef logic [seg_w-1:0]     seg_t;
    typedef logic [reg_num_w-1:0] reg_num_t;

    // Fixed x86 register numbers
    localparam reg_num_t reg_esp = 3'd4;
    localparam reg_num_t reg_esi = 3'd6;
    localparam reg_num_t reg_edi = 3'd7;

    // Segment order is ES, CS, SS, DS, FS, GS
    localparam reg_num_t seg_ss = 3'd2;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } op_size_e;

    typedef enum logic [1:0] {
        opnd_none = 2'd0,
        opnd_gpr  = 2'd1,
        opnd_seg  = 2'd2
    } operand_kind_e;

    typedef enum logic [1:0] {
        stk_none = 2'd0,
        stk_push = 2'd1,
        stk_pop  = 2'd2
    } stack_op_e;

    // Instruction as it leaves decode
    typedef struct packed {
        op_size_e      size;
        operand_kind_e op0_kind;
        reg_num_t      op0_reg;
        operand_kind_e op1_kind;
        reg_num_t      op1_reg;
        logic          writes_op0;
        stack_op_e     stack_op;
        logic          movs;
        gpr_t          pc;
    } decode_t;

    // Instruction handed to address generation
    typedef struct packed {
        decode_t instr;
        gpr_t    op0_value;
        gpr_t    op1_value;
        gpr_t    stack_address;
    } issue_t;

    typedef struct packed {
        logic     en;
        reg_num_t num;
        op_size_e size;
        gpr_t     data;
    } gpr_wb_t;

    typedef struct packed {
        logic     en;
        reg_num_t num;
        seg_t     data;
    } seg_wb_t;

endpackage

`default_nettype wire

// ==== hw/register_access_top.sv ====
// Register access stage top level
// Handshake gating, operand selection and the four sub-blocks
`timescale 1ns/1ps
`default_nettype none

module register_access_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                d_valid,
    output logic                d_ready,
    input  regacc_pkg::decode_t d_instr,
    output logic                r_valid,
    input  logic                r_ready,
    output regacc_pkg::issue_t  r_instr,
    input  regacc_pkg::gpr_wb_t gpr_wb,
    input  regacc_pkg::seg_wb_t seg_wb,
    input  logic                flag_df
);

    logic             stall;
    logic             accept;
    regacc_pkg::gpr_t gpr_rd0;
    regacc_pkg::gpr_t gpr_rd1;
    regacc_pkg::seg_t seg_rd0;
    regacc_pkg::seg_t seg_rd1;
    regacc_pkg::seg_t ss_value;
    regacc_pkg::gpr_t stack_address;

    // Segment values are zero-extended onto the 32-bit operand
    function automatic regacc_pkg::gpr_t operand_sel(input regacc_pkg::operand_kind_e kind,
                                                     input regacc_pkg::gpr_t gpr_value,
                                                     input regacc_pkg::seg_t seg_value);
        case (kind)
            regacc_pkg::opnd_gpr: return gpr_value;
            regacc_pkg::opnd_seg: return {16'b0, seg_value};
            default:              return '0;
        endcase
    endfunction

    // Bypassed stage where the interlock gates both directions
    assign r_valid = d_valid & ~stall;
    assign d_ready = r_ready & ~stall;
    assign accept  = d_valid & d_ready;

    always_comb begin
        r_instr.instr         = d_instr;
        r_instr.op0_value     = operand_sel(d_instr.op0_kind, gpr_rd0, seg_rd0);
        r_instr.op1_value     = operand_sel(d_instr.op1_kind, gpr_rd1, seg_rd1);
        r_instr.stack_address = stack_address;
    end

    gpr_file u_gpr (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd0_num   (d_instr.op0_reg),
        .rd0_data  (gpr_rd0),
        .rd1_num   (d_instr.op1_reg),
        .rd1_data  (gpr_rd1),
        .wb        (gpr_wb),
        .movs_step (accept & d_instr.movs),
        .step_size (d_instr.size),
        .flag_df   (flag_df)
    );

    seg_file u_seg (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd0_num  (d_instr.op0_reg),
        .rd0_data (seg_rd0),
        .rd1_num  (d_instr.op1_reg),
        .rd1_data (seg_rd1),
        .ss_data  (ss_value),
        .wb       (seg_wb)
    );

    write_scoreboard u_scoreboard (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (d_instr),
        .accept     (accept),
        .gpr_wb_en  (gpr_wb.en),
        .gpr_wb_num (gpr_wb.num),
        .seg_wb_en  (seg_wb.en),
        .seg_wb_num (seg_wb.num),
        .stall      (stall)
    );

    stack_pointer_unit u_stack (
        .clk           (clk),
        .rst_n         (rst_n),
        .stack_op      (d_instr.stack_op),
        .size          (d_instr.size),
        .accept        (accept),
        .ss_base       (ss_value),
        .gpr_wb        (gpr_wb),
        .stack_address (stack_address)
    );

endmodule

`default_nettype wire

// ==== hw/seg_file.sv ====
// Segment register file, six 16-bit registers
// Two operand read ports and a dedicated SS port
`timescale 1ns/1ps
`default_nettype none

module seg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  regacc_pkg::reg_num_t rd0_num,
    output regacc_pkg::seg_t     rd0_data,
    input  regacc_pkg::reg_num_t rd1_num,
    output regacc_pkg::seg_t     rd1_data,
    output regacc_pkg::seg_t     ss_data,
    input  regacc_pkg::seg_wb_t  wb
);

    regacc_pkg::seg_t [regacc_pkg::num_seg-1:0] regs;

    // Numbers 6 and 7 name no segment and read as zero
    assign rd0_data = (rd0_num < regacc_pkg::num_seg) ? regs[rd0_num] : '0;
    assign rd1_data = (rd1_num < regacc_pkg::num_seg) ? regs[rd1_num] : '0;
    assign ss_data  = regs[regacc_pkg::seg_ss];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wb.en && wb.num < regacc_pkg::num_seg) begin
            regs[wb.num] <= wb.data;
        end
    end

    // Writeback stage should only target real segments
    a_seg_wb_range: assert property (@(posedge clk) disable iff (!rst_n)
        wb.en |-> wb.num < regacc_pkg::num_seg)
        else $warning("segment writeback to number %0d ignored", wb.num);

endmodule

`default_nettype wire

// ==== hw/stack_pointer_unit.sv ====
// Speculative working ESP for push and pop
// Forms the stack address from SS and the ESP offset
`timescale 1ns/1ps
`default_nettype none

module stack_pointer_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  regacc_pkg::stack_op_e stack_op,
    input  regacc_pkg::op_size_e  size,
    input  logic                  accept,
    input  regacc_pkg::seg_t      ss_base,
    input  regacc_pkg::gpr_wb_t   gpr_wb,
    output regacc_pkg::gpr_t      stack_address
);

    regacc_pkg::gpr_t working_esp;
    regacc_pkg::gpr_t stack_delta;
    regacc_pkg::gpr_t push_esp;
    regacc_pkg::gpr_t pop_esp;
    regacc_pkg::gpr_t offset;
    logic             reload;

    // Byte pushes still move the stack by a word
    assign stack_delta = (size == regacc_pkg::size_dword) ? 32'd4 : 32'd2;
    assign push_esp    = working_esp - stack_delta;
    assign pop_esp     = working_esp + stack_delta;

    // Push writes below the current top, pop reads at it
    assign offset        = (stack_op == regacc_pkg::stk_push) ? push_esp : working_esp;
    assign stack_address = {16'b0, ss_base} + offset;

    // Only a full dword write to ESP resynchronizes the copy
    assign reload = gpr_wb.en && gpr_wb.num == regacc_pkg::reg_esp &&
                    gpr_wb.size == regacc_pkg::size_dword;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            working_esp <= '0;
        end else if (reload) begin
            working_esp <= gpr_wb.data;
        end else if (accept && stack_op == regacc_pkg::stk_push) begin
            working_esp <= push_esp;
        end else if (accept && stack_op == regacc_pkg::stk_pop) begin
            working_esp <= pop_esp;
        end
    end

    // A push never raises ESP unless it wraps below zero or a reload lands
    a_push_moves_down: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && stack_op == regacc_pkg::stk_push && !reload && working_esp >= stack_delta)
        |=> working_esp <= $past(working_esp));

endmodule

`default_nettype wire

// ==== hw/write_scoreboard.sv ====
// Pending-write scoreboard for general and segment registers
// Raises the interlock stall for operands still in flight
`timescale 1ns/1ps
`default_nettype none

module write_scoreboard (
    input  logic                 clk,
    input  logic                 rst_n,
    input  regacc_pkg::decode_t  instr,
    input  logic                 accept,
    input  logic                 gpr_wb_en,
    input  regacc_pkg::reg_num_t gpr_wb_num,
    input  logic                 seg_wb_en,
    input  regacc_pkg::reg_num_t seg_wb_num,
    output logic                 stall
);

    logic [7:0]                     gpr_pend;
    logic [regacc_pkg::num_seg-1:0] seg_pend;

    // Pending state of one source operand
    function automatic logic src_pending(input regacc_pkg::operand_kind_e kind,
                                         input regacc_pkg::reg_num_t num,
                                         input logic [7:0] gpr_bits,
                                         input logic [regacc_pkg::num_seg-1:0] seg_bits);
        case (kind)
            regacc_pkg::opnd_gpr: return gpr_bits[num];
            regacc_pkg::opnd_seg: return (num < regacc_pkg::num_seg) && seg_bits[num];
            default:              return 1'b0;
        endcase
    endfunction

    always_comb begin
        stall = src_pending(instr.op0_kind, instr.op0_reg, gpr_pend, seg_pend)
              | src_pending(instr.op1_kind, instr.op1_reg, gpr_pend, seg_pend);
        // Stack ops read the working ESP, so wait for any ESP write
        if (instr.stack_op != regacc_pkg::stk_none && gpr_pend[regacc_pkg::reg_esp]) begin
            stall = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpr_pend <= '0;
            seg_pend <= '0;
        end else begin
            if (gpr_wb_en) begin
                gpr_pend[gpr_wb_num] <= 1'b0;
            end
            if (seg_wb_en && seg_wb_num < regacc_pkg::num_seg) begin
                seg_pend[seg_wb_num] <= 1'b0;
            end
            // New destination set after the clears, so it wins a same-cycle hit
            if (accept && instr.writes_op0) begin
                if (instr.op0_kind == regacc_pkg::opnd_gpr) begin
                    gpr_pend[instr.op0_reg] <= 1'b1;
                end else if (instr.op0_kind == regacc_pkg::opnd_seg &&
                             instr.op0_reg < regacc_pkg::num_seg) begin
                    seg_pend[instr.op0_reg] <= 1'b1;
                end
            end
        end
    end

    // Top-level handshake has to respect the interlock
    a_no_accept_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> !stall);

endmodule

`default_nettype wire

// ==== sim.f ====
hw/regacc_pkg.sv
hw/gpr_file.sv
hw/seg_file.sv
hw/write_scoreboard.sv
hw/stack_pointer_unit.sv
hw/register_access_top.sv
tb/tb_clock.sv
tb/register_access_tb.sv

// ==== tb/register_access_tb.sv ====
// Testbench for the register access stage
// Directed tests for operands, interlock, string moves and stack
`timescale 1ns/1ps
`default_nettype none

module register_access_tb;

    localparam int num_tests    = 6;
    localparam int reset_cycles = 10;

    logic                clk;
    logic                rst_n;
    logic                d_valid;
    logic                d_ready;
    regacc_pkg::decode_t d_instr;
    logic                r_valid;
    logic                r_ready;
    regacc_pkg::issue_t  r_instr;
    regacc_pkg::gpr_wb_t gpr_wb;
    regacc_pkg::seg_wb_t seg_wb;
    logic                flag_df;
    logic                df_next;

    logic [31:0] rng_state = 32'h8de2_d10d;
    logic [31:0] gpr_model [8];
    logic [15:0] seg_model [6];
    int          error_count = 0;
    int          check_count = 0;
    int          tests_done  = 0;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    register_access_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .d_valid (d_valid),
        .d_ready (d_ready),
        .d_instr (d_instr),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_instr (r_instr),
        .gpr_wb  (gpr_wb),
        .seg_wb  (seg_wb),
        .flag_df (flag_df)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Reference merge where only the bytes covered by the size change
    function automatic logic [31:0] merge_by_size(input logic [31:0] old,
                                                  input logic [31:0] data,
                                                  input regacc_pkg::op_size_e size);
        logic [31:0] mask;
        if (size == regacc_pkg::size_byte) begin
            mask = 32'h0000_00ff;
        end else if (size == regacc_pkg::size_word) begin
            mask = 32'h0000_ffff;
        end else begin
            mask = 32'hffff_ffff;
        end
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic regacc_pkg::decode_t make_read(input regacc_pkg::operand_kind_e k0,
                                                      input regacc_pkg::reg_num_t r0,
                                                      input regacc_pkg::operand_kind_e k1,
                                                      input regacc_pkg::reg_num_t r1);
        regacc_pkg::decode_t instr;
        instr          = '0;
        instr.size     = regacc_pkg::size_dword;
        instr.op0_kind = k0;
        instr.op0_reg  = r0;
        instr.op1_kind = k1;
        instr.op1_reg  = r1;
        instr.pc       = rand_word();
        return instr;
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // Apply on the falling edge, then let outputs settle before sampling
    task automatic drive(input regacc_pkg::decode_t instr, input logic valid, input logic ready);
        @(negedge clk);
        d_instr    = instr;
        d_valid    = valid;
        r_ready    = ready;
        flag_df    = df_next;
        gpr_wb.en  = 1'b0;
        seg_wb.en  = 1'b0;
        #10;
    endtask

    task automatic gpr_write(input regacc_pkg::reg_num_t num, input regacc_pkg::op_size_e size,
                             input logic [31:0] data);
        @(negedge clk);
        d_valid     = 1'b0;
        gpr_wb.en   = 1'b1;
        gpr_wb.num  = num;
        gpr_wb.size = size;
        gpr_wb.data = data;
        @(negedge clk);
        gpr_wb.en = 1'b0;
    endtask

    task automatic seg_write(input regacc_pkg::reg_num_t num, input logic [15:0] data);
        @(negedge clk);
        d_valid     = 1'b0;
        seg_wb.en   = 1'b1;
        seg_wb.num  = num;
        seg_wb.data = data;
        @(negedge clk);
        seg_wb.en = 1'b0;
    endtask

    task automatic report_test(input string test_name, input int errs_before);
        tests_done++;
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", tests_done, test_name);
        end else begin
            $display("test %0d %s: %0d errors", tests_done, test_name, error_count - errs_before);
        end
    endtask

    task automatic test_sized_writeback();
        int                   errs;
        logic [31:0]          data;
        regacc_pkg::op_size_e size;
        regacc_pkg::decode_t  instr;
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            data = rand_word();
            gpr_write(i[2:0], regacc_pkg::size_dword, data);
            gpr_model[i] = data;
        end
        // Byte writes to 1 and 3, word writes to 5 and 7
        for (int i = 1; i < 8; i += 2) begin
            if (i < 4) begin
                size = regacc_pkg::size_byte;
            end else begin
                size = regacc_pkg::size_word;
            end
            data = rand_word();
            gpr_write(i[2:0], size, data);
            gpr_model[i] = merge_by_size(gpr_model[i], data, size);
        end
        for (int i = 0; i < 8; i++) begin
            instr = make_read(regacc_pkg::opnd_gpr, i[2:0], regacc_pkg::opnd_gpr, 3'(7 - i));
            drive(instr, 1'b0, 1'b1);
            check_value("sized_writeback", "op0_value", gpr_model[i], r_instr.op0_value);
            check_value("sized_writeback", "op1_value", gpr_model[7 - i], r_instr.op1_value);
            // Decode fields pass through unchanged
            check_value("sized_writeback", "pc", instr.pc, r_instr.instr.pc);
            check_value("sized_writeback", "fields", 32'(instr >> 32),
                        32'(r_instr.instr >> 32));
        end
        report_test("sized_writeback", errs);
    endtask

    task automatic read_segments(input string test_name);
        int j;
        for (int i = 0; i < 6; i++) begin
            j = (i + 1) % 6;
            drive(make_read(regacc_pkg::opnd_seg, i[2:0], regacc_pkg::opnd_seg, j[2:0]),
                  1'b0, 1'b1);
            check_value(test_name, "op0_value", {16'h0, seg_model[i]}, r_instr.op0_value);
            check_value(test_name, "op1_value", {16'h0, seg_model[j]}, r_instr.op1_value);
        end
    endtask

    task automatic test_segments();
        int errs;
        errs = error_count;
        for (int i = 0; i < 6; i++) begin
            seg_model[i] = 16'(rand_word());
            seg_write(i[2:0], seg_model[i]);
        end
        read_segments("segments");
        // Number 7 names no segment
        seg_write(3'd7, 16'(rand_word()));
        read_segments("segments");
        report_test("segments", errs);
    endtask

    task automatic test_interlock();
        int                  errs;
        logic [31:0]         data;
        regacc_pkg::decode_t writer;
        regacc_pkg::decode_t reader;
        errs   = error_count;
        writer = make_read(regacc_pkg::opnd_gpr, 3'd2, regacc_pkg::opnd_none, 3'd0);
        writer.writes_op0 = 1'b1;
        reader = make_read(regacc_pkg::opnd_gpr, 3'd2, regacc_pkg::opnd_none, 3'd0);
        drive(writer, 1'b1, 1'b1);
        check_value("interlock", "writer d_ready", 1, d_ready);
        for (int i = 0; i < 3; i++) begin
            drive(reader, 1'b1, 1'b1);
            check_value("interlock", "held r_valid", 0, r_valid);
            check_value("interlock", "held d_ready", 0, d_ready);
        end
        drive(make_read(regacc_pkg::opnd_gpr, 3'd3, regacc_pkg::opnd_none, 3'd0), 1'b1, 1'b1);
        check_value("interlock", "reg3 r_valid", 1, r_valid);
        check_value("interlock", "reg3 d_ready", 1, d_ready);
        drive(reader, 1'b1, 1'b1);
        // Writeback lands while the reader still waits
        @(negedge clk);
        data        = rand_word();
        gpr_wb.en   = 1'b1;
        gpr_wb.num  = 3'd2;
        gpr_wb.size = regacc_pkg::size_dword;
        gpr_wb.data = data;
        #10;
        check_value("interlock", "wb cycle r_valid", 0, r_valid);
        gpr_model[2] = data;
        drive(reader, 1'b1, 1'b1);
        check_value("interlock", "released r_valid", 1, r_valid);
        check_value("interlock", "released d_ready", 1, d_ready);
        check_value("interlock", "op0_value", gpr_model[2], r_instr.op0_value);
        drive(reader, 1'b0, 1'b1);
        report_test("interlock", errs);
    endtask

    task automatic test_backpressure();
        int                  errs;
        regacc_pkg::decode_t instr;
        errs       = error_count;
        df_next    = 1'b0;
        instr      = make_read(regacc_pkg::opnd_gpr, regacc_pkg::reg_esi,
                               regacc_pkg::opnd_gpr, regacc_pkg::reg_edi);
        instr.movs = 1'b1;
        for (int i = 0; i < 4; i++) begin
            drive(instr, 1'b1, 1'b0);
            check_value("backpressure", "d_ready", 0, d_ready);
            check_value("backpressure", "esi", gpr_model[6], r_instr.op0_value);
        end
        drive(instr, 1'b1, 1'b1);
        check_value("backpressure", "d_ready", 1, d_ready);
        gpr_model[6] = gpr_model[6] + 4;
        gpr_model[7] = gpr_model[7] + 4;
        for (int i = 0; i < 2; i++) begin
            drive(instr, 1'b0, 1'b1);
            check_value("backpressure", "esi", gpr_model[6], r_instr.op0_value);
        end
        report_test("backpressure", errs);
    endtask

    task automatic test_string_move();
        int                  errs;
        logic [31:0]         step;
        regacc_pkg::decode_t instr;
        errs       = error_count;
        instr      = make_read(regacc_pkg::opnd_gpr, regacc_pkg::reg_esi,
                               regacc_pkg::opnd_gpr, regacc_pkg::reg_edi);
        instr.movs = 1'b1;
        for (int df = 0; df < 2; df++) begin
            for (int k = 0; k < 3; k++) begin
                step       = 32'd1 << k;
                instr.size = regacc_pkg::op_size_e'(k);
                df_next    = df[0];
                drive(instr, 1'b1, 1'b1);
                check_value("string_move", "esi before", gpr_model[6], r_instr.op0_value);
                gpr_model[6] = df ? gpr_model[6] - step : gpr_model[6] + step;
                gpr_model[7] = df ? gpr_model[7] - step : gpr_model[7] + step;
                drive(instr, 1'b0, 1'b1);
                check_value("string_move", "esi after", gpr_model[6], r_instr.op0_value);
                check_value("string_move", "edi after", gpr_model[7], r_instr.op1_value);
            end
        end
        df_next = 1'b0;
        report_test("string_move", errs);
    endtask

    task automatic stack_step(input regacc_pkg::stack_op_e op, input regacc_pkg::op_size_e size,
                              inout logic [31:0] esp, input logic [15:0] ss);
        regacc_pkg::decode_t instr;
        logic [31:0]         amount;
        amount         = (size == regacc_pkg::size_dword) ? 32'd4 : 32'd2;
        instr          = make_read(regacc_pkg::opnd_none, 3'd0, regacc_pkg::opnd_none, 3'd0);
        instr.stack_op = op;
        instr.size     = size;
        if (op == regacc_pkg::stk_push) begin
            esp = esp - amount;
        end
        drive(instr, 1'b1, 1'b1);
        check_value("stack", "stack_address", {16'h0, ss} + esp, r_instr.stack_address);
        if (op == regacc_pkg::stk_pop) begin
            esp = esp + amount;
        end
    endtask

    task automatic test_stack();
        int          errs;
        logic [31:0] esp;
        errs = error_count;
        esp  = (rand_word() & 32'h0000_fff0) | 32'h0001_0000;
        gpr_write(regacc_pkg::reg_esp, regacc_pkg::size_dword, esp);
        gpr_model[4] = esp;
        seg_model[2] = 16'(rand_word());
        seg_write(regacc_pkg::seg_ss, seg_model[2]);
        stack_step(regacc_pkg::stk_push, regacc_pkg::size_word, esp, seg_model[2]);
        stack_step(regacc_pkg::stk_push, regacc_pkg::size_dword, esp, seg_model[2]);
        stack_step(regacc_pkg::stk_pop, regacc_pkg::size_dword, esp, seg_model[2]);
        stack_step(regacc_pkg::stk_pop, regacc_pkg::size_word, esp, seg_model[2]);
        drive(make_read(regacc_pkg::opnd_none, 3'd0, regacc_pkg::opnd_none, 3'd0), 1'b0, 1'b1);
        check_value("stack", "final address", {16'h0, seg_model[2]} + esp,
                    r_instr.stack_address);
        report_test("stack", errs);
    endtask

    initial begin
        repeat (num_tests * 200 + reset_cycles) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        d_valid = 1'b0;
        d_instr = '0;
        r_ready = 1'b0;
        gpr_wb  = '0;
        seg_wb  = '0;
        flag_df = 1'b0;
        df_next = 1'b0;
        @(posedge rst_n);
        test_sized_writeback();
        test_segments();
        test_interlock();
        test_backpressure();
        test_string_move();
        test_stack();
        $display("tests %0d, checks %0d, errors %0d", tests_done, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Clock and reset generator for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int half_period_ns = 20;
    localparam int reset_cycles   = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    // Release on a falling edge like all other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
